// File: all.f
verilog/i2c_pkg.sv
verilog/i2c_bit_ctrl.sv
verilog/i2c_byte_ctrl.sv
verilog/i2c_regs.sv
verilog/i2c_master_top.sv
verification/tb_clock.sv
verification/i2c_slave_model.sv
verification/i2c_tb.sv

// File: run_sim.sh
#!/bin/bash
# Builds and runs the I2C master simulation with Verilator.
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --top-module i2c_tb -f all.f \
  --Mdir obj_dir -o sim_i2c > build.log 2>&1 &&
./obj_dir/sim_i2c > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "ALL TESTS PASSED" sim.log 2> /dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/i2c_tb.sv
`timescale 1ns/1ps

module i2c_tb;
  import i2c_pkg::*;

  localparam int PRESCALE = 4;
  localparam int N_BYTES = 5;
  localparam time WATCHDOG = 2 * (((9 * 4 + 9) * (PRESCALE + 1) * N_BYTES + 8) * 40ns);

  logic     clk;
  logic     nReset;
  bus_req_t req;
  byte_t    dat;
  logic     ack;
  logic     inta;
  logic     scl_oen;
  logic     sda_oen;
  logic     slave_sda_oen;
  logic     scl;
  logic     sda;
  logic     slave_nack;
  logic     slave_read;
  byte_t    slave_tx;
  byte_t    slave_rx;
  logic     slave_master_ack;
  logic     slave_stop_seen;
  int       slave_errors;
  int       errors;
  int       tests;
  int       failed_tests;
  string    cur_test;
  logic [31:0] seed;

  assign scl = scl_oen; // pull-ups on both lines.
  assign sda = sda_oen & slave_sda_oen;

  tb_clock u_clock (.clk_o(clk));

  i2c_master_top uut (
    .clk       (clk),
    .nReset    (nReset),
    .req_i     (req),
    .dat_o     (dat),
    .ack_o     (ack),
    .inta_o    (inta),
    .scl_i     (scl),
    .sda_i     (sda),
    .scl_oen_o (scl_oen),
    .sda_oen_o (sda_oen)
  );

  i2c_slave_model u_slave (
    .scl_i        (scl),
    .sda_i        (sda),
    .nack_i       (slave_nack),
    .read_mode_i  (slave_read),
    .tx_byte_i    (slave_tx),
    .sda_oen_o    (slave_sda_oen),
    .rx_byte_o    (slave_rx),
    .master_ack_o (slave_master_ack),
    .stop_seen_o  (slave_stop_seen),
    .errors_o     (slave_errors)
  );

  single_ack: assert property (@(posedge clk) disable iff (!nReset) ack |=> !ack)
  else
  begin
    $display("Host bus ack stayed high for two cycles");
    errors++;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp)
    else
    begin
      $display("Mismatch %s (%s): expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic bus_access(input reg_addr_t addr, input logic we, input byte_t wdata,
                            output byte_t rdata);
    int  waited;
    logic got;
    waited = 0;
    got = 1'b0;
    rdata = '0;
    @(posedge clk);
    #1;
    req.addr = addr;
    req.wdata = wdata;
    req.we = we;
    req.stb = 1'b1;
    while (!got && waited < 8)
    begin
      @(posedge clk);
      #1;
      waited++;
      got = ack;
    end
    if (got)
      rdata = dat;
    else
      report_failure("host access got no ack");
    req.stb = 1'b0;
    @(posedge clk);
    #1;
    assert (!ack)
    else
      report_failure("host access got a second ack");
  endtask

  task automatic reg_write(input reg_addr_t addr, input byte_t wdata);
    byte_t unused;
    bus_access(addr, 1'b1, wdata, unused);
  endtask

  task automatic reg_read(input reg_addr_t addr, output byte_t rdata);
    bus_access(addr, 1'b0, 8'h00, rdata);
  endtask

  // polls the status register until the transfer is over.
  task automatic wait_transfer(output byte_t status);
    int polls;
    polls = 0;
    reg_read(ADDR_CR_SR, status);
    while (status[1] && polls < 4000)
    begin
      reg_read(ADDR_CR_SR, status);
      polls++;
    end
    if (status[1])
      report_failure("transfer in progress never cleared");
  endtask

  task automatic end_test(input int errors_before);
    tests++;
    if (errors == errors_before)
      $display("test %s: pass", cur_test);
    else
    begin
      $display("test %s: fail", cur_test);
      failed_tests++;
    end
  endtask

  initial
  begin
    #(WATCHDOG);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    byte_t rd;
    byte_t status;
    int    e0;
    int    waited;
    nReset = 1'b0;
    req = '0;
    slave_nack = 1'b0;
    slave_read = 1'b0;
    slave_tx = 8'h00;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    seed = 32'h721c52aa;
    repeat (8) @(posedge clk);
    #1;
    nReset = 1'b1;

    cur_test = "registers";
    e0 = errors;
    reg_read(ADDR_PRER_LO, rd);
    check_value("prer lo reset", 16'hff, {8'h00, rd});
    reg_read(ADDR_PRER_HI, rd);
    check_value("prer hi reset", 16'hff, {8'h00, rd});
    reg_read(ADDR_CTR, rd);
    check_value("ctr reset", 16'h00, {8'h00, rd});
    reg_write(ADDR_PRER_LO, PRESCALE[7:0]);
    reg_write(ADDR_PRER_HI, 8'h00);
    reg_write(ADDR_CTR, 8'h80);
    reg_read(ADDR_PRER_LO, rd);
    check_value("prer lo", PRESCALE[15:0], {8'h00, rd});
    reg_read(ADDR_PRER_HI, rd);
    check_value("prer hi", 16'h00, {8'h00, rd});
    reg_read(ADDR_CTR, rd);
    check_value("ctr", 16'h80, {8'h00, rd});
    end_test(e0);

    cur_test = "write_start";
    e0 = errors;
    reg_write(ADDR_TXR_RXR, 8'ha5);
    reg_write(ADDR_CR_SR, 8'h90); // start and write.
    wait_transfer(status);
    check_value("captured byte", 16'ha5, {8'h00, slave_rx});
    check_value("status", 16'h01, {8'h00, status});
    reg_write(ADDR_CR_SR, 8'h01);
    end_test(e0);

    cur_test = "nack";
    e0 = errors;
    slave_nack = 1'b1;
    reg_write(ADDR_TXR_RXR, 8'h3c);
    reg_write(ADDR_CR_SR, 8'h10);
    wait_transfer(status);
    check_value("captured byte", 16'h3c, {8'h00, slave_rx});
    check_value("status", 16'h81, {8'h00, status});
    reg_write(ADDR_CR_SR, 8'h01);
    slave_nack = 1'b0;
    end_test(e0);

    cur_test = "read";
    e0 = errors;
    seed = lcg_next(seed);
    slave_tx = seed[23:16];
    slave_read = 1'b1;
    reg_write(ADDR_CR_SR, 8'h68); // read with ack_in 1 and stop.
    wait_transfer(status);
    reg_read(ADDR_TXR_RXR, rd);
    check_value("received byte", {8'h00, slave_tx}, {8'h00, rd});
    check_value("master ack", 16'h1, {15'h0, slave_master_ack});
    check_value("status", 16'h81, {8'h00, status});
    reg_write(ADDR_CR_SR, 8'h01);
    slave_read = 1'b0;
    end_test(e0);

    cur_test = "stop_bus_rules";
    e0 = errors;
    check_value("scl released", 16'h1, {15'h0, scl});
    check_value("sda released", 16'h1, {15'h0, sda});
    check_value("stop seen", 16'h1, {15'h0, slave_stop_seen});
    check_value("bus rule errors", 16'h0, slave_errors[15:0]);
    end_test(e0);

    cur_test = "interrupt";
    e0 = errors;
    reg_write(ADDR_CTR, 8'hc0);
    reg_write(ADDR_TXR_RXR, 8'h5a);
    reg_write(ADDR_CR_SR, 8'hd0); // start, write and stop.
    wait_transfer(status);
    waited = 0;
    while (!inta && waited < 4)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    check_value("inta after done", 16'h1, {15'h0, inta});
    reg_write(ADDR_CR_SR, 8'h01);
    repeat (3) @(posedge clk);
    #1;
    check_value("inta after iack", 16'h0, {15'h0, inta});
    reg_read(ADDR_CR_SR, status);
    check_value("flag after iack", 16'h0, {15'h0, status[0]});
    reg_write(ADDR_CTR, 8'h80);
    reg_write(ADDR_CR_SR, 8'hd0);
    wait_transfer(status);
    check_value("flag without ien", 16'h1, {15'h0, status[0]});
    repeat (3) @(posedge clk);
    #1;
    check_value("inta without ien", 16'h0, {15'h0, inta});
    end_test(e0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors + slave_errors);
    if (errors == 0 && slave_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verification/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model (
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic       nack_i,
  input  logic       read_mode_i,
  input  logic [7:0] tx_byte_i,
  output logic       sda_oen_o,
  output logic [7:0] rx_byte_o,
  output logic       master_ack_o,
  output logic       stop_seen_o,
  output int         errors_o
);
  logic       scl_q = 1'b1;
  logic       sda_q = 1'b1;
  logic [3:0] bit_cnt = 4'd0;
  logic [7:0] shift = 8'h00;
  logic       nacked = 1'b0;
  logic       drive = 1'b1;
  logic [7:0] rx_byte = 8'h00;
  logic       master_ack = 1'b0;
  logic       stop_seen = 1'b0;
  int         errors = 0;

  assign sda_oen_o    = drive;
  assign rx_byte_o    = rx_byte;
  assign master_ack_o = master_ack;
  assign stop_seen_o  = stop_seen;
  assign errors_o     = errors;

  always @(scl_i or sda_i or read_mode_i)
  begin
    if (scl_i !== scl_q && scl_i === 1'b1)
    begin
      if (bit_cnt < 4'd8)
      begin
        shift = {shift[6:0], sda_i};
        bit_cnt = bit_cnt + 4'd1;
        if (bit_cnt == 4'd8 && !read_mode_i)
          rx_byte = shift;
      end
      else
      begin
        if (read_mode_i)
        begin
          master_ack = sda_i; // the master's acknowledge bit.
          nacked = sda_i;
        end
        bit_cnt = 4'd0;
      end
    end
    else if (scl_i === 1'b0)
    begin
      if (read_mode_i && bit_cnt < 4'd8 && !nacked)
        drive = tx_byte_i[3'd7 - bit_cnt[2:0]]; // also serves a read set up between bytes.
      else if (!read_mode_i && bit_cnt == 4'd8)
        drive = nack_i;
      else
        drive = 1'b1;
    end
    else if (sda_i !== sda_q && scl_i === 1'b1)
    begin
      assert (bit_cnt <= 4'd1) // a start or stop takes the place of a byte's first bit.
      else
      begin
        $display("Bus error: SDA changed while SCL was high in the middle of a byte");
        errors++;
      end
      if (sda_i === 1'b0)
      begin
        nacked = 1'b0; // start condition.
        stop_seen = 1'b0;
      end
      else
        stop_seen = 1'b1;
      bit_cnt = 4'd0;
    end
    scl_q = scl_i;
    sda_q = sda_i;
  end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);
  localparam time HALF_PERIOD = 20ns; // 40 ns period.

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

// File: verilog/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top (
  input  logic              clk,
  input  logic              nReset,
  input  i2c_pkg::bus_req_t req_i,
  output i2c_pkg::byte_t    dat_o,
  output logic              ack_o,
  output logic              inta_o,
  input  logic              scl_i,
  input  logic              sda_i,
  output logic              scl_oen_o,
  output logic              sda_oen_o
);
  import i2c_pkg::*;

  byte_cmd_t cmd;
  logic      en;
  prescale_t prescale;
  byte_t     txd;
  byte_t     rxd;
  logic      done;
  logic      rx_ack;

  i2c_regs u_regs (
    .clk        (clk),
    .nReset     (nReset),
    .req_i      (req_i),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .inta_o     (inta_o),
    .cmd_o      (cmd),
    .en_o       (en),
    .prescale_o (prescale),
    .txd_o      (txd),
    .done_i     (done),
    .rxd_i      (rxd),
    .rx_ack_i   (rx_ack)
  );

  i2c_byte_ctrl u_byte_ctrl (
    .clk        (clk),
    .nReset     (nReset),
    .en_i       (en),
    .prescale_i (prescale),
    .cmd_i      (cmd),
    .txd_i      (txd),
    .done_o     (done),
    .rxd_o      (rxd),
    .rx_ack_o   (rx_ack),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_oen_o  (scl_oen_o),
    .sda_oen_o  (sda_oen_o)
  );

endmodule

// File: verilog/i2c_regs.sv
`timescale 1ns/1ps

module i2c_regs (
  input  logic               clk,
  input  logic               nReset,
  input  i2c_pkg::bus_req_t  req_i,
  output i2c_pkg::byte_t     dat_o,
  output logic               ack_o,
  output logic               inta_o,
  output i2c_pkg::byte_cmd_t cmd_o,
  output logic               en_o,
  output i2c_pkg::prescale_t prescale_o,
  output i2c_pkg::byte_t     txd_o,
  input  logic               done_i,
  input  i2c_pkg::byte_t     rxd_i,
  input  logic               rx_ack_i
);
  import i2c_pkg::*;

  prescale_t prer;
  byte_t     ctr;
  byte_t     txr;
  byte_t     sr;
  byte_cmd_t cmd_q;
  logic      iack;
  logic      rx_ack_q;
  logic      tip;
  logic      irq_flag;
  logic      wacc;

  assign wacc = req_i.stb & req_i.we & ~ack_o; // a held strobe writes only once.
  assign sr = {rx_ack_q, 5'b0, tip, irq_flag};

  assign cmd_o      = cmd_q;
  assign en_o       = ctr[CTR_EN_BIT];
  assign prescale_o = prer;
  assign txd_o      = txr;

  always_ff @(posedge clk or negedge nReset)
  begin
    if (!nReset)
    begin
      ack_o    <= 1'b0;
      prer     <= PRER_RESET;
      ctr      <= '0;
      cmd_q    <= '0;
      iack     <= 1'b0;
      rx_ack_q <= 1'b0;
      tip      <= 1'b0;
      irq_flag <= 1'b0;
      inta_o   <= 1'b0;
    end
    else
    begin
      ack_o <= req_i.stb & ~ack_o;
      if (wacc && req_i.addr == ADDR_PRER_LO)
        prer[7:0] <= req_i.wdata;
      if (wacc && req_i.addr == ADDR_PRER_HI)
        prer[15:8] <= req_i.wdata;
      if (wacc && req_i.addr == ADDR_CTR)
        ctr <= req_i.wdata;
      if (wacc && req_i.addr == ADDR_CR_SR && ctr[CTR_EN_BIT])
      begin
        cmd_q.start  <= req_i.wdata[CR_STA_BIT];
        cmd_q.stop   <= req_i.wdata[CR_STO_BIT];
        cmd_q.read   <= req_i.wdata[CR_RD_BIT];
        cmd_q.write  <= req_i.wdata[CR_WR_BIT];
        cmd_q.ack_in <= req_i.wdata[CR_ACK_BIT];
        iack         <= req_i.wdata[CR_IACK_BIT];
      end
      else
      begin
        if (done_i)
        begin
          cmd_q.start <= 1'b0; // ack_in stays for the next byte.
          cmd_q.stop  <= 1'b0;
          cmd_q.read  <= 1'b0;
          cmd_q.write <= 1'b0;
        end
        iack <= 1'b0;
      end
      rx_ack_q <= rx_ack_i;
      tip      <= (cmd_q.read | cmd_q.write) & ~done_i;
      irq_flag <= (done_i | irq_flag) & ~iack;
      inta_o   <= irq_flag & ctr[CTR_IEN_BIT];
    end
  end

  always_ff @(posedge clk)
  begin
    if (wacc && req_i.addr == ADDR_TXR_RXR)
      txr <= req_i.wdata;
    case (req_i.addr)
      ADDR_PRER_LO: dat_o <= prer[7:0];
      ADDR_PRER_HI: dat_o <= prer[15:8];
      ADDR_CTR:     dat_o <= ctr;
      ADDR_TXR_RXR: dat_o <= rxd_i;
      ADDR_CR_SR:   dat_o <= sr;
      default:      dat_o <= '0;
    endcase
  end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!nReset) ack_o |=> !ack_o);

endmodule

// File: verilog/i2c_byte_ctrl.sv
`timescale 1ns/1ps

module i2c_byte_ctrl (
  input  logic               clk,
  input  logic               nReset,
  input  logic               en_i,
  input  i2c_pkg::prescale_t prescale_i,
  input  i2c_pkg::byte_cmd_t cmd_i,
  input  i2c_pkg::byte_t     txd_i,
  output logic               done_o,
  output i2c_pkg::byte_t     rxd_o,
  output logic               rx_ack_o,
  input  logic               scl_i,
  input  logic               sda_i,
  output logic               scl_oen_o,
  output logic               sda_oen_o
);
  import i2c_pkg::*;

  byte_state_e state;
  bit_cmd_e    core_cmd;
  logic        core_txd;
  logic        core_ack;
  logic        core_rxd;
  byte_t       sr;
  logic [2:0]  dcnt;
  logic        cnt_done;
  logic        shift;
  logic        ld;
  logic        go;

  i2c_bit_ctrl u_bit_ctrl (
    .clk        (clk),
    .nReset     (nReset),
    .en_i       (en_i),
    .prescale_i (prescale_i),
    .cmd_i      (core_cmd),
    .txd_i      (core_txd),
    .ack_o      (core_ack),
    .rxd_o      (core_rxd),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_oen_o  (scl_oen_o),
    .sda_oen_o  (sda_oen_o)
  );

  assign go = (cmd_i.read | cmd_i.write | cmd_i.stop) & ~done_o; // command is still held in the done cycle.
  assign cnt_done = (dcnt == 3'd0);
  assign ld = (state == B_IDLE) & go;
  assign shift = core_ack & ((state == B_READ) | ((state == B_WRITE) & ~cnt_done));
  assign core_txd = (state == B_ACK) ? cmd_i.ack_in : sr[7];
  assign rxd_o = sr;

  always_comb
  begin
    case (state)
      B_START: core_cmd = BIT_START;
      B_WRITE: core_cmd = BIT_WRITE;
      B_READ:  core_cmd = BIT_READ;
      B_ACK:   core_cmd = cmd_i.read ? BIT_WRITE : BIT_READ; // the ack travels the other way.
      B_STOP:  core_cmd = BIT_STOP;
      default: core_cmd = BIT_NOP;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (ld)
      sr <= txd_i;
    else if (shift)
      sr <= {sr[6:0], core_rxd};
  end

  always_ff @(posedge clk or negedge nReset)
  begin
    if (!nReset)
      dcnt <= 3'd0;
    else if (ld)
      dcnt <= 3'd7;
    else if (shift)
      dcnt <= dcnt - 3'd1;
  end

  always_ff @(posedge clk or negedge nReset)
  begin
    if (!nReset)
    begin
      state    <= B_IDLE;
      done_o   <= 1'b0;
      rx_ack_o <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state)
        B_IDLE:
          if (go)
            state <= cmd_i.start ? B_START : cmd_i.read ? B_READ : cmd_i.write ? B_WRITE : B_STOP;
        B_START:
          if (core_ack)
            state <= cmd_i.read ? B_READ : B_WRITE;
        B_WRITE, B_READ:
          if (core_ack && cnt_done)
            state <= B_ACK;
        B_ACK:
          if (core_ack)
          begin
            rx_ack_o <= core_rxd;
            state    <= cmd_i.stop ? B_STOP : B_IDLE;
            done_o   <= ~cmd_i.stop;
          end
        B_STOP:
          if (core_ack)
          begin
            state  <= B_IDLE;
            done_o <= 1'b1;
          end
        default: state <= B_IDLE;
      endcase
    end
  end

  done_after_ack_or_stop: assert property (@(posedge clk) disable iff (!nReset)
    done_o |-> $past(state) inside {B_ACK, B_STOP});

endmodule

// File: verilog/i2c_bit_ctrl.sv
`timescale 1ns/1ps

module i2c_bit_ctrl (
  input  logic               clk,
  input  logic               nReset,
  input  logic               en_i,
  input  i2c_pkg::prescale_t prescale_i,
  input  i2c_pkg::bit_cmd_e  cmd_i,
  input  logic               txd_i,
  output logic               ack_o,
  output logic               rxd_o,
  input  logic               scl_i,
  input  logic               sda_i,
  output logic               scl_oen_o,
  output logic               sda_oen_o
);
  import i2c_pkg::*;

  prescale_t  cnt;
  logic       clk_en;
  logic [1:0] scl_sync;
  logic [1:0] sda_sync;
  logic       scl_prev;
  bit_state_e state;
  logic       sta_sto;

  assign sta_sto = state inside {ST_START_A, ST_START_B, ST_START_C, ST_START_D, ST_START_E,
                                 ST_STOP_A, ST_STOP_B, ST_STOP_C, ST_STOP_D};

  // each phase is prescale + 1 cycles.
  always_ff @(posedge clk or negedge nReset)
  begin
    if (!nReset)
    begin
      cnt    <= '0;
      clk_en <= 1'b1;
    end
    else if (cnt == '0 || !en_i)
    begin
      cnt    <= prescale_i;
      clk_en <= 1'b1;
    end
    else
    begin
      cnt    <= cnt - 16'd1;
      clk_en <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge nReset)
  begin
    if (!nReset)
    begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_prev <= 1'b1;
      rxd_o    <= 1'b0;
    end
    else
    begin
      scl_sync <= {scl_sync[0], scl_i};
      sda_sync <= {sda_sync[0], sda_i};
      scl_prev <= scl_sync[1];
      if (scl_sync[1] && !scl_prev)
        rxd_o <= sda_sync[1]; // sampled on the rising scl edge.
    end
  end

  always_ff @(posedge clk or negedge nReset)
  begin
    if (!nReset)
    begin
      state     <= ST_IDLE;
      ack_o     <= 1'b0;
      scl_oen_o <= 1'b1;
      sda_oen_o <= 1'b1;
    end
    else
    begin
      ack_o <= 1'b0;
      if (clk_en)
      begin
        case (state)
          ST_IDLE:
            case (cmd_i)
              BIT_START: state <= ST_START_A;
              BIT_STOP:  state <= ST_STOP_A;
              BIT_WRITE: state <= ST_WR_A;
              BIT_READ:  state <= ST_RD_A;
              default:   state <= ST_IDLE;
            endcase
          ST_START_A: state <= ST_START_B;
          ST_START_B: state <= ST_START_C;
          ST_START_C: state <= ST_START_D;
          ST_START_D: state <= ST_START_E;
          ST_STOP_A:  state <= ST_STOP_B;
          ST_STOP_B:  state <= ST_STOP_C;
          ST_STOP_C:  state <= ST_STOP_D;
          ST_RD_A:    state <= ST_RD_B;
          ST_RD_B:    state <= ST_RD_C;
          ST_RD_C:    state <= ST_RD_D;
          ST_WR_A:    state <= ST_WR_B;
          ST_WR_B:    state <= ST_WR_C;
          ST_WR_C:    state <= ST_WR_D;
          default:    state <= ST_IDLE;
        endcase
        // a repeated start keeps scl low through its first phase.
        if (state != ST_IDLE && state != ST_START_A)
          scl_oen_o <= !(state inside {ST_START_E, ST_STOP_A, ST_RD_A, ST_RD_D,
                                       ST_WR_A, ST_WR_D});
        case (state)
          ST_IDLE: sda_oen_o <= sda_oen_o;
          ST_START_A, ST_START_B, ST_STOP_D,
          ST_RD_A, ST_RD_B, ST_RD_C, ST_RD_D: sda_oen_o <= 1'b1;
          ST_WR_A, ST_WR_B, ST_WR_C, ST_WR_D: sda_oen_o <= txd_i;
          default: sda_oen_o <= 1'b0;
        endcase
        ack_o <= state inside {ST_START_E, ST_STOP_D, ST_RD_D, ST_WR_D};
      end
    end
  end

  sda_moves_with_scl_low: assert property (@(posedge clk) disable iff (!nReset)
    $changed(sda_oen_o) |-> !$past(scl_oen_o) || $past(sta_sto));

endmodule

// File: verilog/i2c_pkg.sv
package i2c_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] prescale_t;
  typedef logic [2:0]  reg_addr_t;

  localparam reg_addr_t ADDR_PRER_LO = 3'd0;
  localparam reg_addr_t ADDR_PRER_HI = 3'd1;
  localparam reg_addr_t ADDR_CTR     = 3'd2;
  localparam reg_addr_t ADDR_TXR_RXR = 3'd3; // write transmit, read receive.
  localparam reg_addr_t ADDR_CR_SR   = 3'd4; // write command, read status.

  localparam prescale_t PRER_RESET = 16'hffff;

  localparam int unsigned CTR_EN_BIT  = 7;
  localparam int unsigned CTR_IEN_BIT = 6;

  // Bit positions in the command register.
  localparam int unsigned CR_STA_BIT  = 7;
  localparam int unsigned CR_STO_BIT  = 6;
  localparam int unsigned CR_RD_BIT   = 5;
  localparam int unsigned CR_WR_BIT   = 4;
  localparam int unsigned CR_ACK_BIT  = 3;
  localparam int unsigned CR_IACK_BIT = 0;

  typedef struct packed {
    reg_addr_t addr;
    byte_t     wdata;
    logic      we;
    logic      stb; // strobe already qualified by cycle.
  } bus_req_t;

  typedef struct packed {
    logic start;
    logic stop;
    logic read;
    logic write;
    logic ack_in;
  } byte_cmd_t;

  typedef enum logic [2:0] {
    BIT_NOP, BIT_START, BIT_STOP, BIT_WRITE, BIT_READ
  } bit_cmd_e;

  typedef enum logic [2:0] {
    B_IDLE, B_START, B_WRITE, B_READ, B_ACK, B_STOP
  } byte_state_e;

  typedef enum logic [4:0] {
    ST_IDLE,
    ST_START_A, ST_START_B, ST_START_C, ST_START_D, ST_START_E,
    ST_STOP_A, ST_STOP_B, ST_STOP_C, ST_STOP_D,
    ST_RD_A, ST_RD_B, ST_RD_C, ST_RD_D,
    ST_WR_A, ST_WR_B, ST_WR_C, ST_WR_D
  } bit_state_e;

endpackage
